// ==== include/axi2apb_macros.svh ====
// Widths and FIFO depth for the bridge; data width must be a multiple of 8 and depth at least 1

`ifndef AXI2APB_MACROS_SVH
`define AXI2APB_MACROS_SVH

// ----------------------------------------------------------------------
// Bus widths, one address width shared by AXI and APB
// ----------------------------------------------------------------------
`define AXI2APB_ADDR_W      32
`define AXI2APB_DATA_W      32
`define AXI2APB_ID_W        4

// Entries in every channel buffer
`define AXI2APB_FIFO_DEPTH  4

// ----------------------------------------------------------------------
// AXI response codes, only the two the bridge can return
// ----------------------------------------------------------------------
`define AXI2APB_RESP_OKAY   2'd0
`define AXI2APB_RESP_SLVERR 2'd2

`endif

// ==== src/axi2apb_pkg.sv ====
// Bridge vector types; widths come from the macro header, so change them there only

`default_nettype none

`include "axi2apb_macros.svh"

package axi2apb_pkg;

  // ----------------------------------------------------------------------
  // Payload vectors shared by AXI channels and the APB side
  // ----------------------------------------------------------------------

  // Byte address, same width on AXI and APB
  typedef logic [`AXI2APB_ADDR_W-1:0] addr_t;

  // Read and write data
  typedef logic [`AXI2APB_DATA_W-1:0] data_t;

  // One enable bit per data byte
  typedef logic [`AXI2APB_DATA_W/8-1:0] strb_t;

  // Transaction ID, echoed on B and R
  typedef logic [`AXI2APB_ID_W-1:0] id_t;

  // OKAY or SLVERR
  typedef logic [1:0] resp_t;

endpackage

`default_nettype wire

// ==== src/axi2apb_chan_if.sv ====
// Internal valid/ready channels of the bridge; the B instance of resp_chan_if carries no data

`timescale 1ns/100ps
`default_nettype none

// ----------------------------------------------------------------------
// Address channel, used for AW and AR
// ----------------------------------------------------------------------
interface addr_chan_if import axi2apb_pkg::*; ();
  logic  valid;
  logic  ready;
  id_t   id;
  addr_t addr;

  modport source (output valid, output id, output addr, input ready);
  modport sink   (input valid, input id, input addr, output ready);
endinterface

// ----------------------------------------------------------------------
// Write data channel, a single beat per write
// ----------------------------------------------------------------------
interface wdata_chan_if import axi2apb_pkg::*; ();
  logic  valid;
  logic  ready;
  data_t data;
  strb_t strb;

  modport source (output valid, output data, output strb, input ready);
  modport sink   (input valid, input data, input strb, output ready);
endinterface

// ----------------------------------------------------------------------
// Response channel, used for B and R
// ----------------------------------------------------------------------
interface resp_chan_if import axi2apb_pkg::*; ();
  logic  valid;
  logic  ready;
  id_t   id;
  resp_t resp;
  // Only meaningful on R
  data_t data;

  modport source (output valid, output id, output resp, output data, input ready);
  modport sink   (input valid, input id, input resp, input data, output ready);
endinterface

`default_nettype wire

// ==== src/chan_fifo.sv ====
// Valid/ready FIFO; input ready drops only when full, so a push into a full FIFO waits even if it pops

`timescale 1ns/100ps
`default_nettype none

`include "axi2apb_macros.svh"

module chan_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = `AXI2APB_FIFO_DEPTH
) (
  input  wire logic             ACLK,
  input  wire logic             ARESETn,
  input  wire logic             in_valid_i,
  output logic                  in_ready_o,
  input  wire logic [WIDTH-1:0] in_data_i,
  output logic                  out_valid_o,
  input  wire logic             out_ready_i,
  output logic [WIDTH-1:0]      out_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  // Head entry goes straight out, no output register
  assign out_data_o  = mem[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge ACLK)
  begin
    if (push)
      mem[wr_ptr_q] <= in_data_i;
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  a_no_overflow : assert property (@(posedge ACLK) disable iff (!ARESETn)
    count_q <= CNT_W'(DEPTH));

  // An empty FIFO that wrapped its count would show up here
  a_no_underflow : assert property (@(posedge ACLK) disable iff (!ARESETn)
    (count_q == '0) |=> (count_q <= CNT_W'(1)));

  a_out_stable : assert property (@(posedge ACLK) disable iff (!ARESETn)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));

endmodule

`default_nettype wire

// ==== src/apb_master_fsm.sv ====
// One APB transfer at a time, reads before writes; request heads are held until the response leaves

`timescale 1ns/100ps
`default_nettype none

`include "axi2apb_macros.svh"

module apb_master_fsm import axi2apb_pkg::*; (
  input  wire logic    ACLK,
  input  wire logic    ARESETn,
  addr_chan_if.sink    aw_if,
  wdata_chan_if.sink   w_if,
  addr_chan_if.sink    ar_if,
  resp_chan_if.source  b_if,
  resp_chan_if.source  r_if,
  output logic         psel_o,
  output logic         penable_o,
  output logic         pwrite_o,
  output addr_t        paddr_o,
  output data_t        pwdata_o,
  output strb_t        pstrb_o,
  input  wire data_t   prdata_i,
  input  wire logic    pready_i,
  input  wire logic    pslverr_i
);

  typedef enum logic [2:0] {
    IDLE,
    RD_ACCESS,
    WR_ACCESS,
    RD_RESP,
    WR_RESP
  } bridge_state_e;

  bridge_state_e state_q;
  bridge_state_e state_d;

  // Completion of the access phase
  logic  apb_done;
  data_t rdata_q;
  logic  err_q;

  assign apb_done = penable_o & pready_i;
  // Write data follows the W head, it is stable for as long as the head is held
  assign pwdata_o = w_if.data;

  // ----------------------------------------------------------------------
  // Next state and APB / channel controls
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_d     = state_q;
    psel_o      = 1'b0;
    penable_o   = 1'b0;
    pwrite_o    = 1'b0;
    paddr_o     = ar_if.addr;
    pstrb_o     = '1;
    ar_if.ready = 1'b0;
    aw_if.ready = 1'b0;
    w_if.ready  = 1'b0;
    r_if.valid  = 1'b0;
    b_if.valid  = 1'b0;

    unique case (state_q)
      IDLE:
      begin
        // Setup phase is driven in the same cycle the head shows up
        if (ar_if.valid)
        begin
          psel_o  = 1'b1;
          state_d = RD_ACCESS;
        end
        else if (aw_if.valid && w_if.valid)
        begin
          psel_o   = 1'b1;
          pwrite_o = 1'b1;
          paddr_o  = aw_if.addr;
          pstrb_o  = w_if.strb;
          state_d  = WR_ACCESS;
        end
      end

      RD_ACCESS:
      begin
        psel_o    = 1'b1;
        penable_o = 1'b1;
        if (pready_i)
          state_d = RD_RESP;
      end

      WR_ACCESS:
      begin
        psel_o    = 1'b1;
        penable_o = 1'b1;
        pwrite_o  = 1'b1;
        paddr_o   = aw_if.addr;
        pstrb_o   = w_if.strb;
        if (pready_i)
          state_d = WR_RESP;
      end

      RD_RESP:
      begin
        r_if.valid = 1'b1;
        // AR head is popped only once R is taken
        if (r_if.ready)
        begin
          ar_if.ready = 1'b1;
          state_d     = IDLE;
        end
      end

      WR_RESP:
      begin
        b_if.valid = 1'b1;
        if (b_if.ready)
        begin
          aw_if.ready = 1'b1;
          w_if.ready  = 1'b1;
          state_d     = IDLE;
        end
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // Read data and error flag, sampled in the PREADY cycle
  always_ff @(posedge ACLK)
  begin
    if (apb_done)
    begin
      err_q <= pslverr_i;
      if (!pwrite_o)
        rdata_q <= prdata_i;
    end
  end

  // ----------------------------------------------------------------------
  // Responses, IDs echoed from the held request heads
  // ----------------------------------------------------------------------
  assign r_if.id   = ar_if.id;
  assign r_if.data = rdata_q;
  assign r_if.resp = err_q ? `AXI2APB_RESP_SLVERR : `AXI2APB_RESP_OKAY;

  assign b_if.id   = aw_if.id;
  assign b_if.data = '0;
  assign b_if.resp = err_q ? `AXI2APB_RESP_SLVERR : `AXI2APB_RESP_OKAY;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  a_penable_psel : assert property (@(posedge ACLK) disable iff (!ARESETn)
    penable_o |-> psel_o);

  // Setup and wait cycles must lead into an access with the same address and data
  a_apb_stable : assert property (@(posedge ACLK) disable iff (!ARESETn)
    (psel_o && !apb_done) |=> (psel_o && penable_o && $stable(paddr_o)
                               && $stable(pwrite_o) && (!pwrite_o || $stable(pwdata_o))));

  // The request FIFOs must keep the head until its response is accepted
  a_heads_held : assert property (@(posedge ACLK) disable iff (!ARESETn)
    (r_if.valid |-> ar_if.valid) and (b_if.valid |-> (aw_if.valid && w_if.valid)));

endmodule

`default_nettype wire

// ==== src/axi2apb_bridge.sv ====
// AXI4 to APB bridge for single-beat transfers only; no bursts, LAST or sideband signals

`timescale 1ns/100ps
`default_nettype none

`include "axi2apb_macros.svh"

module axi2apb_bridge import axi2apb_pkg::*; (
  input  wire logic  ACLK,
  input  wire logic  ARESETn,

  // AXI write address
  input  wire id_t   aw_id_i,
  input  wire addr_t aw_addr_i,
  input  wire logic  aw_valid_i,
  output logic       aw_ready_o,

  // AXI write data
  input  wire data_t w_data_i,
  input  wire strb_t w_strb_i,
  input  wire logic  w_valid_i,
  output logic       w_ready_o,

  // AXI write response
  output id_t        b_id_o,
  output resp_t      b_resp_o,
  output logic       b_valid_o,
  input  wire logic  b_ready_i,

  // AXI read address
  input  wire id_t   ar_id_i,
  input  wire addr_t ar_addr_i,
  input  wire logic  ar_valid_i,
  output logic       ar_ready_o,

  // AXI read data
  output id_t        r_id_o,
  output data_t      r_data_o,
  output resp_t      r_resp_o,
  output logic       r_valid_o,
  input  wire logic  r_ready_i,

  // APB
  output logic       psel_o,
  output logic       penable_o,
  output logic       pwrite_o,
  output addr_t      paddr_o,
  output data_t      pwdata_o,
  output strb_t      pstrb_o,
  input  wire data_t prdata_i,
  input  wire logic  pready_i,
  input  wire logic  pslverr_i
);

  localparam int ADDR_CH_W = $bits(id_t) + $bits(addr_t);
  localparam int WDATA_CH_W = $bits(data_t) + $bits(strb_t);
  localparam int B_CH_W = $bits(id_t) + $bits(resp_t);
  localparam int R_CH_W = $bits(id_t) + $bits(resp_t) + $bits(data_t);

  addr_chan_if  aw_if ();
  wdata_chan_if w_if ();
  addr_chan_if  ar_if ();
  resp_chan_if  b_if ();
  resp_chan_if  r_if ();

  // Packed FIFO heads
  logic [ADDR_CH_W-1:0]  aw_head;
  logic [WDATA_CH_W-1:0] w_head;
  logic [ADDR_CH_W-1:0]  ar_head;

  assign {aw_if.id, aw_if.addr} = aw_head;
  assign {w_if.data, w_if.strb} = w_head;
  assign {ar_if.id, ar_if.addr} = ar_head;

  // ----------------------------------------------------------------------
  // Request buffers
  // ----------------------------------------------------------------------
  chan_fifo #(.WIDTH(ADDR_CH_W), .DEPTH(`AXI2APB_FIFO_DEPTH)) u_aw_fifo (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (aw_valid_i),
    .in_ready_o  (aw_ready_o),
    .in_data_i   ({aw_id_i, aw_addr_i}),
    .out_valid_o (aw_if.valid),
    .out_ready_i (aw_if.ready),
    .out_data_o  (aw_head)
  );

  chan_fifo #(.WIDTH(WDATA_CH_W), .DEPTH(`AXI2APB_FIFO_DEPTH)) u_w_fifo (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (w_valid_i),
    .in_ready_o  (w_ready_o),
    .in_data_i   ({w_data_i, w_strb_i}),
    .out_valid_o (w_if.valid),
    .out_ready_i (w_if.ready),
    .out_data_o  (w_head)
  );

  chan_fifo #(.WIDTH(ADDR_CH_W), .DEPTH(`AXI2APB_FIFO_DEPTH)) u_ar_fifo (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (ar_valid_i),
    .in_ready_o  (ar_ready_o),
    .in_data_i   ({ar_id_i, ar_addr_i}),
    .out_valid_o (ar_if.valid),
    .out_ready_i (ar_if.ready),
    .out_data_o  (ar_head)
  );

  // ----------------------------------------------------------------------
  // APB control
  // ----------------------------------------------------------------------
  apb_master_fsm u_fsm (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .aw_if     (aw_if.sink),
    .w_if      (w_if.sink),
    .ar_if     (ar_if.sink),
    .b_if      (b_if.source),
    .r_if      (r_if.source),
    .psel_o    (psel_o),
    .penable_o (penable_o),
    .pwrite_o  (pwrite_o),
    .paddr_o   (paddr_o),
    .pwdata_o  (pwdata_o),
    .pstrb_o   (pstrb_o),
    .prdata_i  (prdata_i),
    .pready_i  (pready_i),
    .pslverr_i (pslverr_i)
  );

  // ----------------------------------------------------------------------
  // Response buffers, B carries no data
  // ----------------------------------------------------------------------
  chan_fifo #(.WIDTH(B_CH_W), .DEPTH(`AXI2APB_FIFO_DEPTH)) u_b_fifo (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (b_if.valid),
    .in_ready_o  (b_if.ready),
    .in_data_i   ({b_if.id, b_if.resp}),
    .out_valid_o (b_valid_o),
    .out_ready_i (b_ready_i),
    .out_data_o  ({b_id_o, b_resp_o})
  );

  chan_fifo #(.WIDTH(R_CH_W), .DEPTH(`AXI2APB_FIFO_DEPTH)) u_r_fifo (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (r_if.valid),
    .in_ready_o  (r_if.ready),
    .in_data_i   ({r_if.id, r_if.resp, r_if.data}),
    .out_valid_o (r_valid_o),
    .out_ready_i (r_ready_i),
    .out_data_o  ({r_id_o, r_resp_o, r_data_o})
  );

endmodule

`default_nettype wire

// ==== sim/tb_apb_target.sv ====
// APB target model with 16 words at address bits 5:2; bit 31 set answers SLVERR, 0 to 2 wait states

`timescale 1ns/100ps
`default_nettype none

module tb_apb_target import axi2apb_pkg::*; (
  input  wire logic  ACLK,
  input  wire logic  ARESETn,
  input  wire logic  psel_i,
  input  wire logic  penable_i,
  input  wire logic  pwrite_i,
  input  wire addr_t paddr_i,
  input  wire data_t pwdata_i,
  input  wire strb_t pstrb_i,
  output data_t      prdata_o,
  output logic       pready_o,
  output logic       pslverr_o
);

  integer      seed = 32'hb5e7037e;
  data_t       mem [16];
  int unsigned wait_q;

  // Fill pattern differs in every word
  initial
  begin
    for (int i = 0; i < 16; i++)
      mem[i] = 32'h0F0F_0000 + i * 32'h0101_0101;
  end

  assign pready_o  = psel_i & penable_i & (wait_q == 0);
  assign pslverr_o = pready_o & paddr_i[31];
  assign prdata_o  = mem[paddr_i[5:2]];

  // ----------------------------------------------------------------------
  // Wait states, drawn during the setup phase
  // ----------------------------------------------------------------------
  always @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      wait_q <= 0;
    else if (psel_i && !penable_i)
      wait_q <= $unsigned($random(seed)) % 3;
    else if (psel_i && penable_i && wait_q != 0)
      wait_q <= wait_q - 1;
  end

  // Byte-lane writes, error region left untouched
  always @(posedge ACLK)
  begin
    if (pready_o && pwrite_i && !paddr_i[31])
    begin
      for (int b = 0; b < $bits(strb_t); b++)
        if (pstrb_i[b])
          mem[paddr_i[5:2]][8*b +: 8] <= pwdata_i[8*b +: 8];
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_axi2apb.sv ====
// Directed testbench for the bridge; stops at the first mismatch, reads only checked after writes

`timescale 1ns/100ps
`default_nettype none

`include "axi2apb_macros.svh"

module tb_axi2apb import axi2apb_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 5000;

  logic  ACLK;
  logic  ARESETn;
  id_t   aw_id_i;
  addr_t aw_addr_i;
  logic  aw_valid_i;
  logic  aw_ready_o;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  w_valid_i;
  logic  w_ready_o;
  id_t   b_id_o;
  resp_t b_resp_o;
  logic  b_valid_o;
  logic  b_ready_i;
  id_t   ar_id_i;
  addr_t ar_addr_i;
  logic  ar_valid_i;
  logic  ar_ready_o;
  id_t   r_id_o;
  data_t r_data_o;
  resp_t r_resp_o;
  logic  r_valid_o;
  logic  r_ready_i;
  logic  psel_o;
  logic  penable_o;
  logic  pwrite_o;
  addr_t paddr_o;
  data_t pwdata_o;
  strb_t pstrb_o;
  data_t prdata_i;
  logic  pready_i;
  logic  pslverr_i;

  // Expected target contents
  data_t exp_mem [16];
  int    cycle_cnt;

  axi2apb_bridge DUT (.*);

  tb_apb_target u_apb_target (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .psel_i    (psel_o),
    .penable_i (penable_o),
    .pwrite_i  (pwrite_o),
    .paddr_i   (paddr_o),
    .pwdata_i  (pwdata_o),
    .pstrb_i   (pstrb_o),
    .prdata_o  (prdata_i),
    .pready_o  (pready_i),
    .pslverr_o (pslverr_i)
  );

  initial
  begin
    ACLK = 1'b0;
    forever #2 ACLK = ~ACLK;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge ACLK);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the bridge stopped responding", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $fatal(1);
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  // ----------------------------------------------------------------------
  // Channel drivers, each entered and left 1 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic issue_requests(input logic wr, input logic rd, input id_t wid,
                                input addr_t waddr, input data_t wdata, input strb_t wstrb,
                                input id_t rid, input addr_t raddr);
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    aw_id_i    = wid;
    aw_addr_i  = waddr;
    w_data_i   = wdata;
    w_strb_i   = wstrb;
    ar_id_i    = rid;
    ar_addr_i  = raddr;
    aw_valid_i = wr;
    w_valid_i  = wr;
    ar_valid_i = rd;
    while (aw_valid_i || w_valid_i || ar_valid_i)
    begin
      @(negedge ACLK);
      aw_hs = aw_valid_i & aw_ready_o;
      w_hs  = w_valid_i & w_ready_o;
      ar_hs = ar_valid_i & ar_ready_o;
      @(posedge ACLK);
      #1;
      if (aw_hs)
        aw_valid_i = 1'b0;
      if (w_hs)
        w_valid_i = 1'b0;
      if (ar_hs)
        ar_valid_i = 1'b0;
    end
  endtask

  task automatic recv_b(input id_t exp_id, input resp_t exp_resp);
    b_ready_i = 1'b1;
    @(negedge ACLK);
    while (!b_valid_o)
      @(negedge ACLK);
    check_id("b_id_o", exp_id, b_id_o);
    check_resp("b_resp_o", exp_resp, b_resp_o);
    @(posedge ACLK);
    #1;
    b_ready_i = 1'b0;
  endtask

  // Read data of an error response is undefined
  task automatic recv_r(input id_t exp_id, input resp_t exp_resp, input data_t exp_data);
    r_ready_i = 1'b1;
    @(negedge ACLK);
    while (!r_valid_o)
      @(negedge ACLK);
    check_id("r_id_o", exp_id, r_id_o);
    check_resp("r_resp_o", exp_resp, r_resp_o);
    if (exp_resp == `AXI2APB_RESP_OKAY)
      check_data("r_data_o", exp_data, r_data_o);
    @(posedge ACLK);
    #1;
    r_ready_i = 1'b0;
  endtask

  function automatic resp_t expected_resp(input addr_t addr);
    return addr[31] ? `AXI2APB_RESP_SLVERR : `AXI2APB_RESP_OKAY;
  endfunction

  task automatic update_model(input addr_t addr, input data_t data, input strb_t strb);
    if (!addr[31])
    begin
      for (int b = 0; b < $bits(strb_t); b++)
        if (strb[b])
          exp_mem[addr[5:2]][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic do_write(input id_t id, input addr_t addr, input data_t data, input strb_t strb);
    issue_requests(1'b1, 1'b0, id, addr, data, strb, '0, '0);
    update_model(addr, data, strb);
    recv_b(id, expected_resp(addr));
  endtask

  task automatic do_read(input id_t id, input addr_t addr);
    issue_requests(1'b0, 1'b1, '0, '0, '0, '0, id, addr);
    recv_r(id, expected_resp(addr), exp_mem[addr[5:2]]);
  endtask

  task automatic check_reset_state;
    check_flag("b_valid_o", 1'b0, b_valid_o);
    check_flag("r_valid_o", 1'b0, r_valid_o);
    check_flag("psel_o", 1'b0, psel_o);
    check_flag("penable_o", 1'b0, penable_o);
  endtask

  // Responses pile up while both readies are low, then drain in issue order
  task automatic stalled_responses;
    for (int i = 0; i < 4; i++)
      do_write(id_t'(i), addr_t'(32'h10 + 4 * i), 32'h5A00_0000 | i, 4'hF);
    for (int i = 0; i < 4; i++)
    begin
      issue_requests(1'b1, 1'b0, id_t'(i), addr_t'(32'h20 + 4 * i), 32'hC0DE_0000 | i, 4'hF,
                     '0, '0);
      update_model(addr_t'(32'h20 + 4 * i), 32'hC0DE_0000 | i, 4'hF);
      issue_requests(1'b0, 1'b1, '0, '0, '0, '0, id_t'(8 + i), addr_t'(32'h10 + 4 * i));
    end
    for (int i = 0; i < 4; i++)
      recv_b(id_t'(i), `AXI2APB_RESP_OKAY);
    for (int i = 0; i < 4; i++)
      recv_r(id_t'(8 + i), `AXI2APB_RESP_OKAY, exp_mem[4 + i]);
  endtask

  task automatic read_priority;
    issue_requests(1'b1, 1'b1, 4'hA, 32'h30, 32'h7777_8888, 4'hF, 4'h9, 32'h00);
    @(negedge ACLK);
    while (!penable_o)
      @(negedge ACLK);
    check_flag("pwrite_o", 1'b0, pwrite_o);
    @(posedge ACLK);
    #1;
    recv_r(4'h9, `AXI2APB_RESP_OKAY, exp_mem[0]);
    update_model(32'h30, 32'h7777_8888, 4'hF);
    recv_b(4'hA, `AXI2APB_RESP_OKAY);
  endtask

  initial
  begin
    ARESETn    = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_valid_i = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b0;
    repeat (4) @(posedge ACLK);
    #1;
    ARESETn = 1'b1;

    check_reset_state();
    do_write(4'h5, 32'h00, 32'hDEAD_BEEF, 4'hF);
    do_read(4'h6, 32'h00);
    do_write(4'h1, 32'h04, 32'h1234_5678, 4'hF);
    do_write(4'h2, 32'h04, 32'hAABB_CCDD, 4'b0101);
    do_read(4'h3, 32'h04);
    do_write(4'h3, 32'h8000_0008, 32'hFFFF_0000, 4'hF);
    do_read(4'h4, 32'h8000_0008);
    stalled_responses();
    read_priority();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
src/axi2apb_pkg.sv
src/axi2apb_chan_if.sv
src/chan_fifo.sv
src/apb_master_fsm.sv
src/axi2apb_bridge.sv
sim/tb_apb_target.sv
sim/tb_axi2apb.sv

// ==== Bender.yml ====
package:
  name: axi2apb_bridge

export_include_dirs:
  - include

sources:
  - src/axi2apb_pkg.sv
  - src/axi2apb_chan_if.sv
  - src/chan_fifo.sv
  - src/apb_master_fsm.sv
  - src/axi2apb_bridge.sv
  - target: simulation
    files:
      - sim/tb_apb_target.sv
      - sim/tb_axi2apb.sv
